//--- design/stim_pkt_pkg.sv
// stimulus entry format, payload and control field shared by memory and sequencer
package stim_pkt_pkg;

   //##########################################################
   // field widths
   //##########################################################
   localparam int STIM_UW = 32;  // payload bits per entry
   localparam int STIM_DW = 3;   // idle cycles after accept, max 7

   // control field, sits in the low bits of each entry
   typedef struct packed
   {
      logic [STIM_DW-1:0] delay;  // pause after this entry is taken
      logic               valid;  // clear marks the end entry
   } stim_ctrl_t;

   // one memory word, 36 bits
   typedef struct packed
   {
      logic [STIM_UW-1:0] payload;  // word presented to the DUT
      stim_ctrl_t         ctrl;
   } stim_entry_t;

endpackage

//--- design/stim_ctrl_pkg.sv
// sequencer state encoding and status word for the stimulus player
package stim_ctrl_pkg;

   localparam int STIM_SENT_W = 16;  // accepted packet counter width

   // read side state, 2 bits
   typedef enum logic [1:0]
   {
      ST_IDLE   = 2'b00,  // waiting for start
      ST_ACTIVE = 2'b01,  // presenting entries
      ST_PAUSE  = 2'b10,  // counting out an entry delay
      ST_DONE   = 2'b11   // end entry seen, sticky until reset
   } stim_state_e;

   // status word seen by the host
   typedef struct packed
   {
      logic                   busy;  // active or pause
      logic                   done;  // end entry reached
      logic [STIM_SENT_W-1:0] sent;  // packets taken by the DUT, saturating
   } stim_status_t;

endpackage

//--- design/stim_mem.sv
// dual-port stimulus memory, host writes on ext_clk and the read port is registered on dut_clk
`timescale 1ns/1ps

module stim_mem
   import stim_pkt_pkg::*;
#(
   parameter int  DEPTH = 64,                                 // entries
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1     // address bits
)
(
   input  logic          nreset,     // async, active low
   input  logic          ext_clk,    // host write clock
   input  logic          load,       // host load window
   input  logic          ext_valid,  // host entry strobe
   input  stim_entry_t   ext_entry,  // entry to store
   input  logic          dut_clk,    // read clock
   input  logic [AW-1:0] rd_addr,    // from sequencer
   output stim_entry_t   rd_entry    // one cycle after rd_addr
);

   logic [AW:0] wr_ptr;  // extra bit so a full table is visible
   logic        wr_en;
   logic        full;

   stim_entry_t mem [DEPTH];  // entry array

   //##########################################################
   // write side, ext_clk domain
   //##########################################################
   assign wr_en = load & ext_valid;  // host handshake
   assign full  = (wr_ptr >= DEPTH);

   always_ff @(posedge ext_clk or negedge nreset)
   begin
      if (!nreset)
         wr_ptr <= '0;
      else if (wr_en && !full)
         wr_ptr <= wr_ptr + 1'b1;  // entries land in order from 0
   end

   always_ff @(posedge ext_clk)
   begin
      if (wr_en && !full)
         mem[wr_ptr[AW-1:0]] <= ext_entry;
   end

   //##########################################################
   // read side, dut_clk domain
   //##########################################################
   always_ff @(posedge dut_clk)
   begin
      rd_entry <= mem[rd_addr];  // single cycle latency
   end

   // host must not load past the table, the extra entries would be dropped
   a_no_overflow: assert property (@(posedge ext_clk) disable iff (!nreset)
      wr_en |-> !full)
      else $error("stim_mem write with table full, wr_ptr %0d", wr_ptr);

endmodule

//--- design/stim_ctrl.sv
// stimulus control, go synchronizer and start pulse plus the busy, done and sent status
`timescale 1ns/1ps

module stim_ctrl
   import stim_ctrl_pkg::*;
(
   input  logic         dut_clk,
   input  logic         nreset,      // async, active low
   input  logic         go,          // level from host, async to dut_clk
   input  stim_state_e  state,       // sequencer state
   input  logic         stim_valid,  // packet offered
   input  logic         dut_ready,   // DUT takes it
   output logic         start,       // one dut_clk wide
   output stim_status_t status
);

   logic [1:0] go_sync;  // two flop synchronizer
   logic       go_q;     // last synced level, for edge detect
   logic       accept;

   //##########################################################
   // go synchronizer and rising edge detect
   //##########################################################
   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         go_sync <= '0;
         go_q    <= 1'b0;
         start   <= 1'b0;
      end
      else
      begin
         go_sync <= {go_sync[0], go};
         go_q    <= go_sync[1];
         start   <= go_sync[1] & ~go_q;  // third edge after go rises
      end
   end

   //##########################################################
   // status register
   //##########################################################
   assign accept = stim_valid & dut_ready;  // DUT handshake

   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
         status <= '0;
      else
      begin
         status.busy <= (state == ST_ACTIVE) || (state == ST_PAUSE);
         status.done <= (state == ST_DONE);
         if (accept && (status.sent != '1))
            status.sent <= status.sent + 1'b1;  // holds at max
      end
   end

   // a second go edge mid run would restart nothing, flag it
   a_start_in_idle: assert property (@(posedge dut_clk) disable iff (!nreset)
      start |-> (state == ST_IDLE))
      else $error("start pulse outside idle, state %s", state.name());

endmodule

//--- design/stim_sequencer.sv
// stimulus read sequencer, steps through entries with delay pause and end detection
`timescale 1ns/1ps

module stim_sequencer
   import stim_pkt_pkg::*;
   import stim_ctrl_pkg::*;
#(
   parameter int  DEPTH = 64,                              // entries
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1  // address bits
)
(
   input  logic               dut_clk,
   input  logic               nreset,       // async, active low
   input  logic               start,        // from stim_ctrl
   input  logic               dut_ready,    // DUT backpressure
   input  stim_entry_t        rd_entry,     // memory data for last rd_addr
   output logic [AW-1:0]      rd_addr,      // to memory
   output stim_state_e        state,        // back to stim_ctrl
   output logic               stim_valid,   // packet offered
   output logic [STIM_UW-1:0] stim_packet   // packet to DUT
);

   logic [STIM_DW-1:0] delay_cnt;  // pause cycles left
   logic               rd_ok;      // rd_entry matches rd_addr
   logic               accept;

   assign accept = stim_valid & dut_ready;

   //##########################################################
   // read state machine
   //##########################################################
   // address and state move only with dut_ready high, except the
   // idle exit, so a start pulse is never lost
   always_ff @(posedge dut_clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state     <= ST_IDLE;
         rd_addr   <= '0;
         delay_cnt <= '0;
         rd_ok     <= 1'b0;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               if (start)
               begin
                  state   <= ST_ACTIVE;
                  rd_addr <= '0;    // table always starts at 0
                  rd_ok   <= 1'b0;  // wait out read latency
               end
            end
            ST_ACTIVE:
            begin
               if (!rd_ok)
                  rd_ok <= 1'b1;  // data for rd_addr lands this edge
               else if (!rd_entry.ctrl.valid)
               begin
                  if (dut_ready)
                     state <= ST_DONE;  // end entry
               end
               else if (accept)
               begin
                  if (rd_entry.ctrl.delay != '0)
                  begin
                     state     <= ST_PAUSE;  // address moves at pause exit
                     delay_cnt <= rd_entry.ctrl.delay;
                  end
                  else
                  begin
                     rd_addr <= rd_addr + 1'b1;
                     rd_ok   <= 1'b0;
                  end
               end
            end
            ST_PAUSE:
            begin
               if (dut_ready)
               begin
                  delay_cnt <= delay_cnt - 1'b1;
                  if (delay_cnt == STIM_DW'(1))  // last idle cycle
                  begin
                     state   <= ST_ACTIVE;
                     rd_addr <= rd_addr + 1'b1;
                     rd_ok   <= 1'b0;
                  end
               end
            end
            default: ;  // ST_DONE holds until reset
         endcase
      end
   end

   //##########################################################
   // output drive
   //##########################################################
   assign stim_valid  = (state == ST_ACTIVE) & rd_ok & rd_entry.ctrl.valid;
   assign stim_packet = rd_entry.payload;  // held while address frozen

   // a stalled packet stays on offer, unchanged, until the DUT takes it
   a_hold_stall: assert property (@(posedge dut_clk) disable iff (!nreset)
      (stim_valid && !dut_ready) |=> (stim_valid && $stable(stim_packet)))
      else $error("stim_packet moved or dropped under back-pressure");

endmodule

//--- design/stim_top.sv
// stimulus player top, joins the entry memory, control block and read sequencer
`timescale 1ns/1ps

module stim_top
   import stim_pkt_pkg::*;
   import stim_ctrl_pkg::*;
#(
   parameter int  DEPTH = 64,                              // table entries
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1  // read address bits
)
(
   input  logic               nreset,       // async, active low
   input  logic               ext_clk,      // host clock
   input  logic               load,         // host load window
   input  logic               ext_valid,    // host entry strobe
   input  stim_entry_t        ext_entry,    // entry from host
   input  logic               dut_clk,      // DUT side clock
   input  logic               go,           // run request level
   input  logic               dut_ready,    // DUT backpressure
   output logic               stim_valid,   // packet offered
   output logic [STIM_UW-1:0] stim_packet,  // packet to DUT
   output stim_status_t       status        // busy, done, sent
);

   logic          start;     // ctrl to sequencer
   logic [AW-1:0] rd_addr;   // sequencer to memory
   stim_entry_t   rd_entry;  // memory to sequencer
   stim_state_e   state;     // sequencer to ctrl

   //##########################################################
   // entry memory
   //##########################################################
   stim_mem #(.DEPTH(DEPTH)) stim_mem_inst
   (
      .nreset    (nreset),
      .ext_clk   (ext_clk),
      .load      (load),
      .ext_valid (ext_valid),
      .ext_entry (ext_entry),
      .dut_clk   (dut_clk),
      .rd_addr   (rd_addr),
      .rd_entry  (rd_entry)
   );

   // go sync and status
   stim_ctrl stim_ctrl_inst
   (
      .dut_clk    (dut_clk),
      .nreset     (nreset),
      .go         (go),
      .state      (state),
      .stim_valid (stim_valid),
      .dut_ready  (dut_ready),
      .start      (start),
      .status     (status)
   );

   //##########################################################
   // read sequencer
   //##########################################################
   stim_sequencer #(.DEPTH(DEPTH)) stim_sequencer_inst
   (
      .dut_clk     (dut_clk),
      .nreset      (nreset),
      .start       (start),
      .dut_ready   (dut_ready),
      .rd_entry    (rd_entry),
      .rd_addr     (rd_addr),
      .state       (state),
      .stim_valid  (stim_valid),
      .stim_packet (stim_packet)
   );

endmodule

//--- testbench/tb_clkgen.sv
// testbench clock and reset source, dut_clk and ext_clk at 40 ns, reset low for 2 cycles
`timescale 1ns/1ps

module tb_clkgen
(
   input  logic rst_req,  // rising edge asks for a reset
   output logic dut_clk,
   output logic ext_clk,  // host write clock, same period
   output logic nreset    // async, active low
);

   initial
   begin
      dut_clk = 1'b0;
      nreset  = 1'b0;  // low from time zero until the first request ends
      forever #20 dut_clk = ~dut_clk;
   end

   initial
   begin
      ext_clk = 1'b0;
      #10;  // quarter period skew, host clock is unrelated
      forever #20 ext_clk = ~ext_clk;
   end

   // request comes on a falling edge, release two falling edges later
   always @(posedge rst_req)
   begin
      nreset = 1'b0;
      repeat (2) @(negedge dut_clk);
      nreset = 1'b1;
   end

endmodule

//--- testbench/tb_checker.sv
// testbench checker, compares accepted packets, gaps and final status with the expected table
`timescale 1ns/1ps

module tb_checker
   import stim_pkt_pkg::*;
   import stim_ctrl_pkg::*;
#(
   parameter int MAX_ENT = 16  // longest expected table
)
(
   input  logic               dut_clk,
   input  logic               nreset,
   input  logic               stim_valid,
   input  logic               dut_ready,
   input  logic [STIM_UW-1:0] stim_packet,
   input  stim_status_t       status,
   input  logic [STIM_UW-1:0] exp_payload [MAX_ENT],  // expected order
   input  logic [STIM_DW-1:0] exp_delay [MAX_ENT],    // delay per entry
   input  int                 exp_count,              // packets owed
   input  int                 test_num,
   input  logic               check,                  // end of test strobe
   output int                 errors,
   output int                 tests_done,
   output int                 tests_failed
);

   int                 idx;          // next expected entry
   int                 since_acc;    // idle edges since last accept
   int                 last_delay;   // gap owed by last accepted entry
   int                 test_err;
   logic               stalled;      // offered but not taken last edge
   logic [STIM_UW-1:0] held_packet;

   task automatic mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
      $display("error test %0d %s got %h exp %h", test_num, sig, got, exp);
      test_err++;
   endtask

   initial
   begin
      errors       = 0;
      tests_done   = 0;
      tests_failed = 0;
   end

   // sampled on the rising edge, inputs move on the falling one
   always @(posedge dut_clk)
   begin
      if (!nreset)
      begin
         idx        = 0;
         since_acc  = 0;
         last_delay = 0;
         test_err   = 0;
         stalled    = 1'b0;
      end
      else
      begin
         //##########################################################
         // per edge, hold under back-pressure and accept order
         //##########################################################
         if (stalled && !stim_valid)
            mismatch("stim_valid", 32'(stim_valid), 32'd1);  // dropped while stalled
         if (stalled && (stim_packet != held_packet))
            mismatch("stim_packet", stim_packet, held_packet);
         if (stim_valid && (idx >= exp_count))
            mismatch("stim_valid", 32'(stim_valid), 32'd0);  // past the end entry
         else if (stim_valid && dut_ready)
         begin
            if (stim_packet != exp_payload[idx])
               mismatch("stim_packet", stim_packet, exp_payload[idx]);
            if ((idx > 0) && (since_acc < last_delay))
               mismatch("accept_gap", 32'(since_acc), 32'(last_delay));  // exp is a floor
            if (!status.busy)
               mismatch("status.busy", 32'(status.busy), 32'd1);  // mid run
            last_delay = 32'(exp_delay[idx]);
            idx++;
            since_acc = 0;
         end
         else
            since_acc++;
         stalled     = stim_valid && !dut_ready;
         held_packet = stim_packet;
         // end of test, status after done
         if (check)
         begin
            if (idx != exp_count)
               mismatch("accepted", 32'(idx), 32'(exp_count));
            if (!status.done)
               mismatch("status.done", 32'(status.done), 32'd1);
            if (status.busy)
               mismatch("status.busy", 32'(status.busy), 32'd0);
            if (32'(status.sent) != 32'(exp_count))
               mismatch("status.sent", 32'(status.sent), 32'(exp_count));
            errors += test_err;
            tests_done++;
            if (test_err != 0)
               tests_failed++;
            $display("test %0d: %0d packets, %0d errors, %s", test_num, idx, test_err,
                     (test_err == 0) ? "ok" : "fail");
         end
      end
   end

endmodule

//--- testbench/tb_stim_top.sv
// testbench top for the stimulus player, table driven runs with lfsr payloads and ready
`timescale 1ns/1ps

module tb_stim_top
   import stim_pkt_pkg::*;
   import stim_ctrl_pkg::*;
#(
   parameter int DEPTH   = 64,  // table depth of the DUT
   parameter int MAX_ENT = 16   // longest test
)
();

   localparam int NTESTS = 5;

   typedef struct packed
   {
      logic [7:0] count;      // valid entries loaded
      logic [2:0] max_dly;    // entry delay drawn from 0 up to this
      logic       bp;         // random dut_ready
      logic       end_first;  // end entry at address 0
   } test_row_t;

   test_row_t tests [NTESTS] = '{
      '{8'd8,  3'd0, 1'b0, 1'b0},   // in order, ready held high
      '{8'd12, 3'd3, 1'b0, 1'b0},   // delay gaps
      '{8'd12, 3'd0, 1'b1, 1'b0},   // back-pressure only
      '{8'd16, 3'd7, 1'b1, 1'b0},   // both at once
      '{8'd6,  3'd2, 1'b0, 1'b1}    // empty table
   };

   logic               dut_clk, ext_clk, nreset, rst_req;
   logic               load, ext_valid, go, dut_ready, stim_valid, check;
   stim_entry_t        ext_entry;
   logic [STIM_UW-1:0] stim_packet;
   stim_status_t       status;
   logic [STIM_UW-1:0] exp_payload [MAX_ENT];
   logic [STIM_DW-1:0] exp_delay [MAX_ENT];
   int                 exp_count, test_num, errors, tests_done, tests_failed;
   logic [31:0]        lfsr;
   int                 cycles = 0;
   int                 limit;

   tb_clkgen clkgen_inst (.*);
   stim_top #(.DEPTH(DEPTH)) stim_top_inst (.*);
   tb_checker #(.MAX_ENT(MAX_ENT)) checker_inst (.*);

   // galois lfsr, n bits out, one shift per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] bits;
      bits = '0;
      for (int i = 0; i < n; i++)
      begin
         bits = {bits[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return bits;
   endfunction

   task automatic load_entry(input stim_entry_t e);
      @(negedge ext_clk);
      load      = 1'b1;
      ext_valid = 1'b1;
      ext_entry = e;  // written on the next ext_clk rise
   endtask

   always @(posedge dut_clk)
   begin
      cycles++;
      if (cycles > limit)
      begin
         $display("timeout, done never came within %0d dut_clk cycles", limit);
         $display("*** FAILED ***");
         $finish;
      end
   end

   initial
   begin
      stim_entry_t e;
      test_row_t   row;
      logic [31:0] d;
      lfsr      = 32'hf731_6323;
      rst_req   = 1'b0;
      load      = 1'b0;
      ext_valid = 1'b0;
      ext_entry = '0;
      go        = 1'b0;
      dut_ready = 1'b0;
      check     = 1'b0;
      exp_count = 0;
      test_num  = 0;
      limit     = 0;
      for (int t = 0; t < NTESTS; t++)
         limit += int'(tests[t].count) * (int'(tests[t].max_dly) + 1) * 4 + 20;
      //##########################################################
      // test loop
      //##########################################################
      for (int t = 0; t < NTESTS; t++)
      begin
         row      = tests[t];
         test_num = t;
         for (int i = 0; i < int'(row.count); i++)
         begin
            exp_payload[i] = take_bits(32);
            d              = take_bits(3) % (32'(row.max_dly) + 32'd1);
            exp_delay[i]   = d[STIM_DW-1:0];
         end
         exp_count = row.end_first ? 0 : int'(row.count);
         @(negedge dut_clk);
         go      = 1'b0;
         rst_req = 1'b1;
         @(posedge nreset);
         rst_req = 1'b0;
         if (row.end_first)
            load_entry('0);  // nothing behind it may show
         for (int i = 0; i < int'(row.count); i++)
         begin
            e.payload    = exp_payload[i];
            e.ctrl.delay = exp_delay[i];
            e.ctrl.valid = 1'b1;
            load_entry(e);
         end
         load_entry('0);  // closing end entry
         @(negedge ext_clk);
         load      = 1'b0;
         ext_valid = 1'b0;
         @(negedge dut_clk);
         go = 1'b1;
         while (!status.done)
         begin
            dut_ready = row.bp ? (take_bits(2) != 32'd0) : 1'b1;  // about 3 in 4 high
            @(negedge dut_clk);
         end
         check = 1'b1;  // checker reads status on the next rise
         @(negedge dut_clk);
         check     = 1'b0;
         dut_ready = 1'b0;
      end
      $display("%0d tests, %0d failed, %0d errors", tests_done, tests_failed, errors);
      if ((errors == 0) && (tests_done == NTESTS))
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

//--- build.f
design/stim_pkt_pkg.sv
design/stim_ctrl_pkg.sv
design/stim_mem.sv
design/stim_ctrl.sv
design/stim_sequencer.sv
design/stim_top.sv
testbench/tb_clkgen.sv
testbench/tb_checker.sv
testbench/tb_stim_top.sv

//--- Makefile
# verilator build and run of the stimulus player testbench
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_stim_top
FILELIST  := build.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
